// File: verilog/dbg_cpu_settings.svh
/* Debug unit settings */

`ifndef DBG_CPU_SETTINGS_SVH
`define DBG_CPU_SETTINGS_SVH

// Control register width, bit 1 is cpu reset and bit 0 is stall
`define DBG_STATUS_LEN 2

// SPR port widths as seen by the CPU
`define DBG_SPR_ADDR_W 16
`define DBG_SPR_DATA_W 32

// Command buffer entries, which is also the host's credit count after reset
`define DBG_CMD_CREDITS 2

// Depth of each clock-crossing FIFO, must be a power of two
`define DBG_CDC_DEPTH 4

`endif

// File: verilog/dbg_cmd_pkg.sv
/* Debug host channel types */

`default_nettype none

`include "dbg_cpu_settings.svh"

package dbg_cmd_pkg;

  // Command opcodes sent by the debug host
  typedef enum logic [1:0] {
    write_ctrl = 2'd0,
    read_ctrl  = 2'd1,
    spr_write  = 2'd2,
    spr_read   = 2'd3
  } dbg_op_e;

  // One host command
  // For write_ctrl only the low DBG_STATUS_LEN bits of data are used
  typedef struct packed {
    dbg_op_e                     op;
    logic [`DBG_SPR_ADDR_W-1:0]  addr;
    logic [`DBG_SPR_DATA_W-1:0]  data;
  } dbg_cmd_t;

  // One response back to the host, op is echoed from the command
  // Writes return zero data
  typedef struct packed {
    dbg_op_e                     op;
    logic [`DBG_SPR_DATA_W-1:0]  data;
  } dbg_rsp_t;

endpackage

`default_nettype wire

// File: verilog/dbg_cpu_pkg.sv
/* Debug CPU side types */

`default_nettype none

`include "dbg_cpu_settings.svh"

package dbg_cpu_pkg;

  // Control register layout, matches the host view of the status bits
  typedef struct packed {
    logic cpu_reset;
    logic stall;
  } dbg_ctrl_t;

  // A single SPR access queued towards the CPU clock domain
  typedef struct packed {
    logic                        we;
    logic [`DBG_SPR_ADDR_W-1:0]  addr;
    logic [`DBG_SPR_DATA_W-1:0]  wdata;
  } spr_req_t;

  // Result of an SPR access, returned for writes as well
  typedef struct packed {
    logic [`DBG_SPR_DATA_W-1:0]  rdata;
  } spr_rsp_t;

endpackage

`default_nettype wire

// File: verilog/dbg_cdc_fifo.sv
/* Asynchronous FIFO */

`default_nettype none

`include "dbg_cpu_settings.svh"

module dbg_cdc_fifo #(
  parameter type payload_t = logic
) (
  input  wire logic     rst_i,
  // Write side
  input  wire logic     wclk_i,
  input  wire logic     wpush_i,
  input  wire payload_t wdata_i,
  output logic          wfull_o,
  // Read side
  input  wire logic     rclk_i,
  input  wire logic     rpop_i,
  output payload_t      rdata_o,
  output logic          rempty_o
);

  localparam int DEPTH  = `DBG_CDC_DEPTH;
  localparam int ADDR_W = $clog2(DEPTH);

  // One extra pointer bit tells full from empty
  typedef logic [ADDR_W:0] ptr_t;

  payload_t mem [DEPTH];

  ptr_t wbin;
  ptr_t wbin_next;
  ptr_t wgray;
  ptr_t rbin;
  ptr_t rbin_next;
  ptr_t rgray;

  // Gray pointers after crossing into the other domain
  ptr_t rgray_meta;
  ptr_t rgray_sync;
  ptr_t wgray_meta;
  ptr_t wgray_sync;

  logic wr_en;
  logic rd_en;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  ////////////////////
  // Write domain

  assign wr_en     = wpush_i && !wfull_o;
  assign wbin_next = wbin + ptr_t'(wr_en);

  always_ff @(posedge wclk_i or posedge rst_i) begin
    if (rst_i) begin
      wbin  <= '0;
      wgray <= '0;
    end else begin
      wbin  <= wbin_next;
      wgray <= bin2gray(wbin_next);
    end
  end

  always_ff @(posedge wclk_i) begin
    if (wr_en) begin
      mem[wbin[ADDR_W-1:0]] <= wdata_i;
    end
  end

  always_ff @(posedge wclk_i or posedge rst_i) begin
    if (rst_i) begin
      rgray_meta <= '0;
      rgray_sync <= '0;
    end else begin
      rgray_meta <= rgray;
      rgray_sync <= rgray_meta;
    end
  end

  // Full when the write pointer is one lap ahead of the stale read pointer
  // In Gray code that means the two top bits differ and the rest match
  assign wfull_o = (wgray == {~rgray_sync[ADDR_W:ADDR_W-1], rgray_sync[ADDR_W-2:0]});

  ////////////////////
  // Read domain

  assign rd_en     = rpop_i && !rempty_o;
  assign rbin_next = rbin + ptr_t'(rd_en);

  always_ff @(posedge rclk_i or posedge rst_i) begin
    if (rst_i) begin
      rbin  <= '0;
      rgray <= '0;
    end else begin
      rbin  <= rbin_next;
      rgray <= bin2gray(rbin_next);
    end
  end

  always_ff @(posedge rclk_i or posedge rst_i) begin
    if (rst_i) begin
      wgray_meta <= '0;
      wgray_sync <= '0;
    end else begin
      wgray_meta <= wgray;
      wgray_sync <= wgray_meta;
    end
  end

  // Empty uses a late copy of the write pointer, so it may clear late
  assign rempty_o = (rgray == wgray_sync);

  // Show-ahead read, the head entry is visible whenever not empty
  assign rdata_o = mem[rbin[ADDR_W-1:0]];

endmodule

`default_nettype wire

// File: verilog/dbg_cpu_status_reg.sv
/* Debug stall and reset register */

`default_nettype none

module dbg_cpu_status_reg
  import dbg_cpu_pkg::*;
(
  input  wire logic      tck_i,
  input  wire logic      cpu_clk_i,
  input  wire logic      rst_i,
  input  wire logic      we_i,
  input  wire dbg_ctrl_t data_i,
  input  wire logic      bp_i,
  output dbg_ctrl_t      ctrl_o,
  output logic           cpu_stall_o,
  output logic           cpu_rst_o
);

  ////////////////////
  // State

  // Breakpoint latch and its copy in the tck domain
  logic bp_latch_q;
  logic bp_tck_meta;
  logic bp_tck_q;

  // Host visible control bits
  logic host_stall_q;
  logic host_reset_q;

  // Host bits seen from the CPU clock
  logic stall_cpu_meta;
  logic stall_cpu_q;
  logic reset_cpu_meta;

  ////////////////////
  // CPU clock domain

  // A breakpoint can only set the latch, so the CPU stays stopped until
  // the host has seen the stall and released it through its own stall bit
  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      bp_latch_q <= 1'b0;
    end else if (bp_i) begin
      bp_latch_q <= 1'b1;
    end else if (stall_cpu_q) begin
      bp_latch_q <= 1'b0;
    end
  end

  // Two flop synchronizers for both host bits
  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      stall_cpu_meta <= 1'b0;
      stall_cpu_q    <= 1'b0;
      reset_cpu_meta <= 1'b0;
      cpu_rst_o      <= 1'b0;
    end else begin
      stall_cpu_meta <= host_stall_q;
      stall_cpu_q    <= stall_cpu_meta;
      reset_cpu_meta <= host_reset_q;
      cpu_rst_o      <= reset_cpu_meta;
    end
  end

  // The raw breakpoint stalls at once, the latch and host bit keep it
  assign cpu_stall_o = bp_i | bp_latch_q | stall_cpu_q;

  ////////////////////
  // JTAG clock domain

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bp_tck_meta <= 1'b0;
      bp_tck_q    <= 1'b0;
    end else begin
      bp_tck_meta <= bp_latch_q;
      bp_tck_q    <= bp_tck_meta;
    end
  end

  // Stall is set by the host or a breakpoint, but only the host clears it
  // The breakpoint wins while its latch is still visible here
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      host_stall_q <= 1'b0;
      host_reset_q <= 1'b0;
    end else begin
      if (bp_tck_q) begin
        host_stall_q <= 1'b1;
      end else if (we_i) begin
        host_stall_q <= data_i.stall;
      end
      if (we_i) begin
        host_reset_q <= data_i.cpu_reset;
      end
    end
  end

  // Readback for the command decoder
  assign ctrl_o = '{cpu_reset: host_reset_q, stall: host_stall_q};

endmodule

`default_nettype wire

// File: verilog/dbg_cpu_cmd_decoder.sv
/* Debug command decoder */

`default_nettype none

`include "dbg_cpu_settings.svh"

module dbg_cpu_cmd_decoder
  import dbg_cmd_pkg::*;
  import dbg_cpu_pkg::*;
(
  input  wire logic      tck_i,
  input  wire logic      rst_i,
  input  wire logic      cmd_valid_i,
  input  wire dbg_cmd_t  cmd_i,
  input  wire dbg_ctrl_t ctrl_i,
  input  wire logic      req_full_i,
  input  wire logic      rsp_empty_i,
  input  wire spr_rsp_t  rsp_data_i,
  output logic           cmd_credit_o,
  output logic           rsp_valid_o,
  output dbg_rsp_t       rsp_o,
  output logic           ctrl_we_o,
  output dbg_ctrl_t      ctrl_data_o,
  output logic           req_push_o,
  output spr_req_t       req_data_o,
  output logic           rsp_pop_o
);

  localparam int DEPTH = `DBG_CMD_CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_exec,
    st_wait
  } state_e;

  ////////////////////
  // Command buffer

  dbg_cmd_t           buf_mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               take;

  state_e                      state;
  dbg_cmd_t                    cur_cmd;
  logic                        is_spr;
  logic                        finish_ctrl;
  logic [`DBG_SPR_DATA_W-1:0]  ctrl_word;

  // Wrap a buffer pointer, the depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // The host holds a credit for every free slot, so no overflow check here
  always_ff @(posedge tck_i) begin
    if (cmd_valid_i) begin
      buf_mem[wr_ptr] <= cmd_i;
    end
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (cmd_valid_i) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (take) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CNT_W'(cmd_valid_i) - CNT_W'(take);
    end
  end

  // Oldest command leaves the buffer only when the engine is free
  assign take = (state == st_idle) && (count != '0);

  always_ff @(posedge tck_i) begin
    if (take) begin
      cur_cmd <= buf_mem[rd_ptr];
    end
  end

  ////////////////////
  // Execution

  assign is_spr      = (cur_cmd.op == spr_write) || (cur_cmd.op == spr_read);
  assign finish_ctrl = (state == st_exec) && !is_spr;
  assign ctrl_word   = {{(`DBG_SPR_DATA_W - `DBG_STATUS_LEN){1'b0}}, ctrl_i};

  // Control writes happen in the execute cycle
  assign ctrl_we_o   = (state == st_exec) && (cur_cmd.op == write_ctrl);
  assign ctrl_data_o = dbg_ctrl_t'(cur_cmd.data[`DBG_STATUS_LEN-1:0]);

  // SPR requests wait here for room in the request FIFO
  assign req_push_o = (state == st_exec) && is_spr && !req_full_i;
  assign req_data_o = '{we: (cur_cmd.op == spr_write), addr: cur_cmd.addr,
                        wdata: cur_cmd.data};
  assign rsp_pop_o  = (state == st_wait) && !rsp_empty_i;

  // One command in flight keeps responses in command order
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state        <= st_idle;
      rsp_valid_o  <= 1'b0;
      cmd_credit_o <= 1'b0;
    end else begin
      rsp_valid_o  <= 1'b0;
      cmd_credit_o <= 1'b0;
      case (state)
        st_idle: begin
          if (take) begin
            state <= st_exec;
          end
        end
        st_exec: begin
          if (finish_ctrl) begin
            rsp_valid_o  <= 1'b1;
            cmd_credit_o <= 1'b1;
            state        <= st_idle;
          end else if (req_push_o) begin
            state <= st_wait;
          end
        end
        st_wait: begin
          if (rsp_pop_o) begin
            rsp_valid_o  <= 1'b1;
            cmd_credit_o <= 1'b1;
            state        <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Response payload, qualified by rsp_valid_o
  always_ff @(posedge tck_i) begin
    if (finish_ctrl) begin
      rsp_o.op   <= cur_cmd.op;
      rsp_o.data <= (cur_cmd.op == read_ctrl) ? ctrl_word : '0;
    end else if (rsp_pop_o) begin
      rsp_o.op   <= cur_cmd.op;
      rsp_o.data <= (cur_cmd.op == spr_read) ? rsp_data_i.rdata : '0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/dbg_cpu_spr_master.sv
/* SPR access engine */

`default_nettype none

`include "dbg_cpu_settings.svh"

module dbg_cpu_spr_master
  import dbg_cpu_pkg::*;
(
  input  wire logic                        cpu_clk_i,
  input  wire logic                        rst_i,
  input  wire logic                        req_empty_i,
  input  wire spr_req_t                    req_i,
  input  wire logic                        rsp_full_i,
  input  wire logic                        spr_ack_i,
  input  wire logic [`DBG_SPR_DATA_W-1:0]  spr_rdata_i,
  output logic                             req_pop_o,
  output logic                             rsp_push_o,
  output spr_rsp_t                         rsp_o,
  output logic                             spr_stb_o,
  output logic                             spr_we_o,
  output logic [`DBG_SPR_ADDR_W-1:0]       spr_addr_o,
  output logic [`DBG_SPR_DATA_W-1:0]       spr_wdata_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_access,
    st_reply
  } state_e;

  state_e   state;
  spr_req_t req_q;

  // Take a new request only between accesses
  assign req_pop_o  = (state == st_idle) && !req_empty_i;
  assign rsp_push_o = (state == st_reply) && !rsp_full_i;

  // Strobe comes straight from the state, so it falls the cycle after ack
  assign spr_stb_o   = (state == st_access);
  assign spr_we_o    = req_q.we;
  assign spr_addr_o  = req_q.addr;
  assign spr_wdata_o = req_q.wdata;

  always_ff @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:   if (req_pop_o) state <= st_access;
        st_access: if (spr_ack_i) state <= st_reply;
        st_reply:  if (rsp_push_o) state <= st_idle;
        default:   state <= st_idle;
      endcase
    end
  end

  // Request and read data are held for the whole access
  always_ff @(posedge cpu_clk_i) begin
    if (req_pop_o) begin
      req_q <= req_i;
    end
    if ((state == st_access) && spr_ack_i) begin
      rsp_o.rdata <= spr_rdata_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/dbg_cpu_top.sv
/* Debug unit CPU interface */

`default_nettype none

`include "dbg_cpu_settings.svh"

module dbg_cpu_top
  import dbg_cmd_pkg::*;
  import dbg_cpu_pkg::*;
(
  input  wire logic                        cpu_clk_i,
  input  wire logic                        tck_i,
  input  wire logic                        rst_i,
  input  wire logic                        cmd_valid_i,
  input  wire dbg_cmd_t                    cmd_i,
  input  wire logic                        bp_i,
  input  wire logic                        spr_ack_i,
  input  wire logic [`DBG_SPR_DATA_W-1:0]  spr_rdata_i,
  output logic                             cmd_credit_o,
  output logic                             rsp_valid_o,
  output dbg_rsp_t                         rsp_o,
  output logic                             cpu_stall_o,
  output logic                             cpu_rst_o,
  output logic                             spr_stb_o,
  output logic                             spr_we_o,
  output logic [`DBG_SPR_ADDR_W-1:0]       spr_addr_o,
  output logic [`DBG_SPR_DATA_W-1:0]       spr_wdata_o
);

  ////////////////////
  // Wires

  // Control register access, tck domain
  logic      ctrl_we;
  dbg_ctrl_t ctrl_wdata;
  dbg_ctrl_t ctrl_rdata;

  // Request path from tck to cpu_clk
  logic     req_push;
  spr_req_t req_wdata;
  logic     req_full;
  logic     req_pop;
  spr_req_t req_rdata;
  logic     req_empty;

  // Response path from cpu_clk back to tck
  logic     rsp_push;
  spr_rsp_t rsp_wdata;
  logic     rsp_full;
  logic     rsp_pop;
  spr_rsp_t rsp_rdata;
  logic     rsp_empty;

  ////////////////////
  // Instances

  dbg_cpu_cmd_decoder i_decoder (
    .tck_i        (tck_i),
    .rst_i        (rst_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_i        (cmd_i),
    .ctrl_i       (ctrl_rdata),
    .req_full_i   (req_full),
    .rsp_empty_i  (rsp_empty),
    .rsp_data_i   (rsp_rdata),
    .cmd_credit_o (cmd_credit_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o),
    .ctrl_we_o    (ctrl_we),
    .ctrl_data_o  (ctrl_wdata),
    .req_push_o   (req_push),
    .req_data_o   (req_wdata),
    .rsp_pop_o    (rsp_pop)
  );

  dbg_cpu_status_reg i_status_reg (
    .tck_i       (tck_i),
    .cpu_clk_i   (cpu_clk_i),
    .rst_i       (rst_i),
    .we_i        (ctrl_we),
    .data_i      (ctrl_wdata),
    .bp_i        (bp_i),
    .ctrl_o      (ctrl_rdata),
    .cpu_stall_o (cpu_stall_o),
    .cpu_rst_o   (cpu_rst_o)
  );

  dbg_cdc_fifo #(.payload_t(spr_req_t)) i_req_fifo (
    .rst_i    (rst_i),
    .wclk_i   (tck_i),
    .wpush_i  (req_push),
    .wdata_i  (req_wdata),
    .wfull_o  (req_full),
    .rclk_i   (cpu_clk_i),
    .rpop_i   (req_pop),
    .rdata_o  (req_rdata),
    .rempty_o (req_empty)
  );

  dbg_cdc_fifo #(.payload_t(spr_rsp_t)) i_rsp_fifo (
    .rst_i    (rst_i),
    .wclk_i   (cpu_clk_i),
    .wpush_i  (rsp_push),
    .wdata_i  (rsp_wdata),
    .wfull_o  (rsp_full),
    .rclk_i   (tck_i),
    .rpop_i   (rsp_pop),
    .rdata_o  (rsp_rdata),
    .rempty_o (rsp_empty)
  );

  dbg_cpu_spr_master i_spr_master (
    .cpu_clk_i   (cpu_clk_i),
    .rst_i       (rst_i),
    .req_empty_i (req_empty),
    .req_i       (req_rdata),
    .rsp_full_i  (rsp_full),
    .spr_ack_i   (spr_ack_i),
    .spr_rdata_i (spr_rdata_i),
    .req_pop_o   (req_pop),
    .rsp_push_o  (rsp_push),
    .rsp_o       (rsp_wdata),
    .spr_stb_o   (spr_stb_o),
    .spr_we_o    (spr_we_o),
    .spr_addr_o  (spr_addr_o),
    .spr_wdata_o (spr_wdata_o)
  );

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
/* Testbench clock source */

`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD = 100
) (
  output logic clk_o
);

  // Free running clock, low for the first half period
  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: testbench/tb_cpu_spr_model.sv
/* Behavioral CPU SPR file */

`default_nettype none

module tb_cpu_spr_model #(
  parameter logic [31:0] SEED = 32'h7e33
) (
  input  wire logic        cpu_clk_i,
  input  wire logic        rst_i,
  input  wire logic        spr_stb_i,
  input  wire logic        spr_we_i,
  input  wire logic [15:0] spr_addr_i,
  input  wire logic [31:0] spr_wdata_i,
  output logic             spr_ack_o,
  output logic [31:0]      spr_rdata_o
);

  // Sparse SPR space, only written registers are stored
  logic [31:0] mem [logic [15:0]];
  integer      seed = SEED;
  int          delay;

  // Unwritten registers read back a pattern built from the whole address
  function automatic logic [31:0] spr_value(input logic [15:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return {~addr, addr};
  endfunction

  // Each access waits 0 to 5 cycles before the ack
  always @(posedge cpu_clk_i or posedge rst_i) begin
    if (rst_i) begin
      spr_ack_o   <= 1'b0;
      spr_rdata_o <= '0;
      delay       = 0;
    end else begin
      spr_ack_o <= 1'b0;
      if (spr_stb_i && !spr_ack_o) begin
        if (delay == 0) begin
          spr_ack_o   <= 1'b1;
          spr_rdata_o <= spr_value(spr_addr_i);
          if (spr_we_i) begin
            mem[spr_addr_i] = spr_wdata_i;
          end
          delay = {$random(seed)} % 6;
        end else begin
          delay = delay - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_dbg_cpu.sv
/* Debug unit testbench */

`default_nettype none

`include "dbg_cpu_settings.svh"

module tb_dbg_cpu
  import dbg_cmd_pkg::*;
();

  localparam int CREDITS   = `DBG_CMD_CREDITS;
  localparam int MAX_CYCLE = 4000;

  logic        cpu_clk_i;
  logic        tck_i;
  logic        rst_i;
  logic        cmd_valid_i;
  dbg_cmd_t    cmd_i;
  logic        bp_i;
  logic        spr_ack_i;
  logic [31:0] spr_rdata_i;
  logic        cmd_credit_o;
  logic        rsp_valid_o;
  dbg_rsp_t    rsp_o;
  logic        cpu_stall_o;
  logic        cpu_rst_o;
  logic        spr_stb_o;
  logic        spr_we_o;
  logic [15:0] spr_addr_o;
  logic [31:0] spr_wdata_o;

  // Host side bookkeeping
  dbg_rsp_t exp_q [$];
  dbg_rsp_t exp;
  int       issued = 0;
  int       returned = 0;
  int       cycles = 0;
  logic     started = 1'b0;
  integer   seed = 32'h7e33;

  // SPR commands still waiting for their access on the CPU port
  dbg_cmd_t spr_q [$];
  dbg_cmd_t acc;

  // High while a breakpoint stall must hold the CPU
  logic     stall_hold = 1'b0;

  tb_clk_gen #(.PERIOD(100)) i_cpu_clk (.clk_o(cpu_clk_i));
  tb_clk_gen #(.PERIOD(170)) i_tck (.clk_o(tck_i));

  dbg_cpu_top i_dut (.*);

  tb_cpu_spr_model #(.SEED(32'h7e33)) i_spr_model (
    .cpu_clk_i   (cpu_clk_i),
    .rst_i       (rst_i),
    .spr_stb_i   (spr_stb_o),
    .spr_we_i    (spr_we_o),
    .spr_addr_i  (spr_addr_o),
    .spr_wdata_i (spr_wdata_o),
    .spr_ack_o   (spr_ack_i),
    .spr_rdata_o (spr_rdata_i)
  );

  task automatic stop_failed(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  ////////////////////
  // Assertions

  // Quiet outputs from reset until the first command
  assert property (@(posedge cpu_clk_i) !started |-> !cpu_stall_o && !cpu_rst_o && !spr_stb_o)
    else stop_failed("outputs active after reset before the first command");
  assert property (@(posedge tck_i) !started |-> !rsp_valid_o && !cmd_credit_o)
    else stop_failed("response or credit before the first command");

  // Breakpoint stalls in its own cycle and the latch keeps the stall
  assert property (@(posedge cpu_clk_i) disable iff (rst_i) $rose(bp_i) |-> $rose(cpu_stall_o))
    else stop_failed("cpu_stall_o did not rise in the cycle of the bp_i pulse");
  assert property (@(posedge cpu_clk_i) disable iff (rst_i) stall_hold |-> cpu_stall_o)
    else stop_failed("mismatch cpu_stall_o exp 1 got 0 after bp_i");

  // Strobe is held until the CPU acks
  assert property (@(posedge cpu_clk_i) disable iff (rst_i) spr_stb_o && !spr_ack_i |=> spr_stb_o)
    else stop_failed("mismatch spr_stb_o exp 1 got 0 before spr_ack_i");

  // Credits come back only for commands the host has sent
  assert property (@(posedge tck_i) returned <= issued)
    else stop_failed("credit returned with no command outstanding");

  // Responses in command order, every credit pulse retires one command
  always @(posedge tck_i) begin
    if (!rst_i && cmd_credit_o) begin
      returned++;
    end
    if (!rst_i && rsp_valid_o) begin
      if (exp_q.size() == 0) begin
        stop_failed("response arrived with no command outstanding");
      end else begin
        exp = exp_q.pop_front();
        assert (rsp_o.op == exp.op)
          else stop_failed($sformatf("mismatch rsp_o.op exp %h got %h", exp.op, rsp_o.op));
        assert (rsp_o.data == exp.data)
          else stop_failed($sformatf("mismatch rsp_o.data exp %h got %h", exp.data, rsp_o.data));
      end
    end
  end

  // Each acked access carries the direction, address and write data of its command
  always @(posedge cpu_clk_i) begin
    if (!rst_i && spr_stb_o && spr_ack_i) begin
      if (spr_q.size() == 0) begin
        stop_failed("SPR access with no SPR command outstanding");
      end else begin
        acc = spr_q.pop_front();
        assert (spr_we_o == (acc.op == spr_write))
          else stop_failed($sformatf("mismatch spr_we_o exp %h got %h",
                                     acc.op == spr_write, spr_we_o));
        assert (spr_addr_o == acc.addr)
          else stop_failed($sformatf("mismatch spr_addr_o exp %h got %h",
                                     acc.addr, spr_addr_o));
        if (acc.op == spr_write) begin
          assert (spr_wdata_o == acc.data)
            else stop_failed($sformatf("mismatch spr_wdata_o exp %h got %h",
                                       acc.data, spr_wdata_o));
        end
      end
    end
  end

  // Run limit, about five times the expected length
  always @(posedge cpu_clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLE) begin
      stop_failed("timeout, the run did not finish within 4000 cpu cycles");
    end
  end

  ////////////////////
  // Host driver

  task automatic send_cmd(input dbg_op_e op, input logic [15:0] addr,
                          input logic [31:0] data, input logic [31:0] exp_data);
    @(posedge tck_i);
    while ((CREDITS - issued + returned) <= 0) begin
      @(posedge tck_i);
    end
    cmd_valid_i <= 1'b1;
    cmd_i       <= '{op: op, addr: addr, data: data};
    issued++;
    started = 1'b1;
    exp_q.push_back('{op: op, data: exp_data});
    if (op == spr_write || op == spr_read) begin
      spr_q.push_back('{op: op, addr: addr, data: data});
    end
    @(posedge tck_i);
    cmd_valid_i <= 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge tck_i);
    end
  endtask

  // Wait a bounded number of cpu cycles for stall or reset to reach a level
  task automatic expect_level(input bit is_rst, input logic val, input int bound);
    int   n;
    logic got;
    for (n = 0; n <= bound; n++) begin
      @(posedge cpu_clk_i);
      got = is_rst ? cpu_rst_o : cpu_stall_o;
      if (got == val) begin
        return;
      end
    end
    stop_failed($sformatf("mismatch %s exp %h got %h", is_rst ? "cpu_rst_o" : "cpu_stall_o",
                          val, got));
  endtask

  task automatic write_ctrl_and_check(input logic rst_bit, input logic stall_bit);
    send_cmd(write_ctrl, '0, {30'd0, rst_bit, stall_bit}, '0);
    // The register is written on the tck edge that raises the response
    @(posedge rsp_valid_o);
    expect_level(1'b1, rst_bit, 3);
    expect_level(1'b0, stall_bit, 3);
    send_cmd(read_ctrl, '0, '0, {30'd0, rst_bit, stall_bit});
    drain();
  endtask

  initial begin
    logic [15:0] addr;
    logic [31:0] data;
    rst_i       = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    bp_i        = 1'b0;
    repeat (8) @(posedge cpu_clk_i);
    rst_i <= 1'b0;
    repeat (4) @(posedge tck_i);

    write_ctrl_and_check(1'b0, 1'b1);
    write_ctrl_and_check(1'b1, 1'b0);
    write_ctrl_and_check(1'b1, 1'b1);
    write_ctrl_and_check(1'b0, 1'b0);

    // Breakpoint pulse, seen by the host as a set stall bit
    @(posedge cpu_clk_i);
    bp_i <= 1'b1;
    @(posedge cpu_clk_i);
    bp_i       <= 1'b0;
    stall_hold = 1'b1;
    repeat (12) @(posedge cpu_clk_i);
    send_cmd(read_ctrl, '0, '0, 32'h1);
    drain();
    repeat (12) @(posedge cpu_clk_i);
    stall_hold = 1'b0;
    send_cmd(write_ctrl, '0, '0, '0);
    @(posedge rsp_valid_o);
    expect_level(1'b0, 1'b0, 4);
    drain();

    // SPR write then read back, issued back to back
    repeat (6) begin
      addr = $random(seed);
      data = $random(seed);
      send_cmd(spr_write, addr, data, '0);
      send_cmd(spr_read, addr, '0, data);
    end
    drain();
    repeat (4) @(posedge tck_i);

    if (issued != returned) begin
      stop_failed($sformatf("mismatch returned credits exp %h got %h", issued, returned));
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verilog
verilog/dbg_cmd_pkg.sv
verilog/dbg_cpu_pkg.sv
verilog/dbg_cdc_fifo.sv
verilog/dbg_cpu_status_reg.sv
verilog/dbg_cpu_cmd_decoder.sv
verilog/dbg_cpu_spr_master.sv
verilog/dbg_cpu_top.sv
testbench/tb_clk_gen.sv
testbench/tb_cpu_spr_model.sv
testbench/tb_dbg_cpu.sv
